//--- src/logger_settings.svh
// ================================================
// sizing for the accelerometer logger
// LOG_RING_DEPTH must be a power of two
// LOG_SCLK_HALF of 1 or more, sclk = clk / (2*half)
// ================================================
`ifndef LOGGER_SETTINGS_SVH
`define LOGGER_SETTINGS_SVH

// clk cycles per half sclk period
`define LOG_SCLK_HALF 2

// ring capacity in bytes
`define LOG_RING_DEPTH 32

// credits the host owns after reset
`define LOG_HOST_CREDITS 4

`define LOG_LEN_W 6  // burst length field
`define LOG_DIV_W 16 // sync divider, sync counter, register data

`endif

//--- src/adxl_pkg.sv
// ================================================
// ADXL355 spi protocol definitions
// command byte is {addr[6:0], rd}, rd=1 reads
// ================================================
`default_nettype none

package adxl_pkg;

  // command byte, shifted out raw, built from fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [6:0] addr; // register address
      logic       rd;   // 1 read, 0 write
    } f;
  } adxl_cmd_u;

  localparam logic [6:0] ADXL_REG_DEVID  = 7'h00; // analog devices id, 0xad
  localparam logic [6:0] ADXL_REG_XDATA3 = 7'h08; // x,y,z 20-bit, 9 bytes
  localparam logic [6:0] ADXL_REG_FIFO   = 7'h11; // fifo data port

endpackage

`default_nettype wire

//--- src/logger_pkg.sv
// ================================================
// host register map, 3-bit word index
// ================================================
`default_nettype none

package logger_pkg;

  localparam logic [2:0] REG_CTRL      = 3'd0; // bit0 enable
  localparam logic [2:0] REG_CMD       = 3'd1; // write addr[6:0], reads cmd byte
  localparam logic [2:0] REG_LEN       = 3'd2; // data bytes per burst
  localparam logic [2:0] REG_DIV       = 3'd3; // clk cycles per sync
  localparam logic [2:0] REG_EXPECT    = 3'd4; // syncs per pps interval
  localparam logic [2:0] REG_STAT_SYNC = 3'd5; // ro, last interval count
  localparam logic [2:0] REG_STAT_DROP = 3'd6; // ro, dropped bytes
  localparam logic [2:0] REG_STAT_LOCK = 3'd7; // ro, bit0 locked

endpackage

`default_nettype wire

//--- src/pps_sync_gen.sv
// ================================================
// sync generator, phase restarts on each pps rise
// div must be 2 or more; pps may be asynchronous
// sync_count valid from the second pps edge on
// ================================================
`timescale 1ns/1ps
`default_nettype none
`include "logger_settings.svh"

module pps_sync_gen (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   pps,
  input  wire [`LOG_DIV_W-1:0]  div,
  input  wire [`LOG_DIV_W-1:0]  expect_syncs,
  output logic                  sync,       // to sensor SYNC/DRDY
  output logic                  sync_tick,  // one cycle per period
  output logic [`LOG_DIV_W-1:0] sync_count,
  output logic                  locked
);

  logic [2:0]            pps_sr;     // 2 sync flops + edge history
  logic                  pps_rise;
  logic                  boundary;   // last cycle of a period
  logic [`LOG_DIV_W-1:0] phase;
  logic [`LOG_DIV_W-1:0] phase_next;
  logic [`LOG_DIV_W-1:0] tick_cnt;   // ticks in current interval
  logic                  pps_seen;
  logic                  cnt_valid;  // sync_count covers a full interval

  assign pps_rise   = pps_sr[1] & ~pps_sr[2];
  assign boundary   = phase >= div - 1'b1; // >= so a shrunk div still wraps
  assign phase_next = (pps_rise || boundary) ? '0 : phase + 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pps_sr     <= '0;
      phase      <= '0;
      sync       <= 1'b0;
      sync_tick  <= 1'b0;
      tick_cnt   <= '0;
      sync_count <= '0;
      pps_seen   <= 1'b0;
      cnt_valid  <= 1'b0;
      locked     <= 1'b0;
    end
    else
    begin
      pps_sr    <= {pps_sr[1:0], pps};
      phase     <= phase_next;
      sync_tick <= pps_rise | boundary; // pps wins over a coinciding boundary
      sync      <= phase_next < (div >> 1); // high for first half
      if (pps_rise)
      begin
        pps_seen   <= 1'b1;
        cnt_valid  <= pps_seen; // first interval after reset is partial
        sync_count <= tick_cnt;
        tick_cnt   <= {{(`LOG_DIV_W-1){1'b0}}, 1'b1}; // tick at the edge itself
      end
      else if (boundary)
        tick_cnt <= tick_cnt + 1'b1;
      locked <= cnt_valid && (sync_count == expect_syncs);
    end
  end

endmodule

`default_nettype wire

//--- src/logger_regs.sv
// ================================================
// host configuration and status registers
// write lands on the next edge, read is comb
// cmd writes always set the read bit
// ================================================
`timescale 1ns/1ps
`default_nettype none
`include "logger_settings.svh"

module logger_regs (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    reg_wr,
  input  wire [2:0]              reg_addr,
  input  wire [`LOG_DIV_W-1:0]   reg_wdata,
  input  wire [`LOG_DIV_W-1:0]   sync_count,
  input  wire                    locked,
  input  wire [`LOG_DIV_W-1:0]   drop_count,
  output logic [`LOG_DIV_W-1:0]  reg_rdata,
  output logic                   enable,
  output adxl_pkg::adxl_cmd_u    cmd,
  output logic [`LOG_LEN_W-1:0]  len,
  output logic [`LOG_DIV_W-1:0]  div,
  output logic [`LOG_DIV_W-1:0]  expect_syncs
);

  localparam int DW = `LOG_DIV_W;
  localparam int LW = `LOG_LEN_W;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      enable       <= 1'b0;
      cmd.f.addr   <= adxl_pkg::ADXL_REG_DEVID; // id read, safe default
      cmd.f.rd     <= 1'b1;
      len          <= LW'(3);   // one 20-bit axis
      div          <= DW'(100);
      expect_syncs <= DW'(10);
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        logger_pkg::REG_CTRL:   enable       <= reg_wdata[0];
        logger_pkg::REG_CMD:
        begin
          cmd.f.addr <= reg_wdata[6:0];
          cmd.f.rd   <= 1'b1; // reader only reads
        end
        logger_pkg::REG_LEN:    len          <= reg_wdata[LW-1:0];
        logger_pkg::REG_DIV:    div          <= reg_wdata;
        logger_pkg::REG_EXPECT: expect_syncs <= reg_wdata;
        default: ; // status words are read only
      endcase
    end
  end

  always_comb
  begin
    reg_rdata = '0;
    case (reg_addr)
      logger_pkg::REG_CTRL:      reg_rdata[0]      = enable;
      logger_pkg::REG_CMD:       reg_rdata[7:0]    = cmd.raw;
      logger_pkg::REG_LEN:       reg_rdata[LW-1:0] = len;
      logger_pkg::REG_DIV:       reg_rdata         = div;
      logger_pkg::REG_EXPECT:    reg_rdata         = expect_syncs;
      logger_pkg::REG_STAT_SYNC: reg_rdata         = sync_count;
      logger_pkg::REG_STAT_DROP: reg_rdata         = drop_count;
      logger_pkg::REG_STAT_LOCK: reg_rdata[0]      = locked;
      default:                   reg_rdata         = '0;
    endcase
  end

  // sync generator needs at least a 2-cycle period
  a_div_min: assert property (@(posedge clk) disable iff (rst)
    (reg_wr && reg_addr == logger_pkg::REG_DIV) |=> (div >= DW'(2)));

endmodule

`default_nettype wire

//--- src/adxl_spi_reader.sv
// ================================================
// ADXL355 burst reader, spi mode 0, msb first
// one burst per accepted sync_tick, busy ticks lost
// keeps data bytes 0,1 of every 3, drops the 3rd
// ================================================
`timescale 1ns/1ps
`default_nettype none
`include "logger_settings.svh"

module adxl_spi_reader (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   enable,
  input  adxl_pkg::adxl_cmd_u   cmd,
  input  wire [`LOG_LEN_W-1:0]  len,
  input  wire                   sync_tick,
  input  wire                   adxl_miso,
  output logic                  adxl_csn,
  output logic                  adxl_sclk,
  output logic                  adxl_mosi,
  output logic                  byte_wr,
  output logic [7:0]            byte_data
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CMD  = 2'd1; // command byte out
  localparam logic [1:0] ST_DATA = 2'd2; // len bytes in
  localparam logic [1:0] ST_REL  = 2'd3; // csn hold before release

  localparam int HW = $clog2(`LOG_SCLK_HALF + 1);
  localparam logic [HW-1:0] HALF_LAST = HW'(`LOG_SCLK_HALF - 1);

  logic [1:0]            state;
  logic [HW-1:0]         hcnt;      // clk cycles within half sclk
  logic [2:0]            bit_cnt;
  logic [7:0]            tx_sr;
  logic [7:0]            rx_sr;
  logic [`LOG_LEN_W-1:0] byte_idx;
  logic [1:0]            keep_ph;   // data index mod 3
  logic                  half_done;

  assign half_done = hcnt == HALF_LAST;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= ST_IDLE;
      hcnt      <= '0;
      bit_cnt   <= '0;
      byte_idx  <= '0;
      keep_ph   <= '0;
      adxl_csn  <= 1'b1;
      adxl_sclk <= 1'b0;
      adxl_mosi <= 1'b0;
      byte_wr   <= 1'b0;
    end
    else
    begin
      byte_wr <= 1'b0; // single cycle strobe
      case (state)
        ST_IDLE:
        if (enable && sync_tick)
        begin
          state     <= ST_CMD;
          adxl_csn  <= 1'b0;
          tx_sr     <= cmd.raw;
          adxl_mosi <= cmd.raw[7]; // first bit set up before first rise
          hcnt      <= '0;
          bit_cnt   <= '0;
          byte_idx  <= '0;
          keep_ph   <= '0;
        end
        ST_CMD, ST_DATA:
        begin
          hcnt <= half_done ? '0 : hcnt + 1'b1;
          if (half_done && !adxl_sclk)
          begin
            adxl_sclk <= 1'b1;
            rx_sr     <= {rx_sr[6:0], adxl_miso}; // sample on rise
          end
          else if (half_done)
          begin
            adxl_sclk <= 1'b0;
            bit_cnt   <= bit_cnt + 1'b1;
            adxl_mosi <= tx_sr[6]; // shift on fall, zeros after cmd
            tx_sr     <= {tx_sr[6:0], 1'b0};
            if (bit_cnt == 3'd7)
            begin
              if (state == ST_CMD)
                state <= (len == '0) ? ST_REL : ST_DATA;
              else
              begin
                byte_wr   <= keep_ph != 2'd2; // 3rd byte holds the 4 lsbs
                byte_data <= rx_sr;
                keep_ph   <= (keep_ph == 2'd2) ? 2'd0 : keep_ph + 1'b1;
                byte_idx  <= byte_idx + 1'b1;
                if (byte_idx == len - 1'b1)
                  state <= ST_REL;
              end
            end
          end
        end
        ST_REL:
        begin
          hcnt <= half_done ? '0 : hcnt + 1'b1;
          if (half_done)
          begin
            adxl_csn <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // csn only rises once all len data bytes are clocked
  a_csn_burst: assert property (@(posedge clk) disable iff (rst)
    $rose(adxl_csn) |-> (byte_idx == len));

endmodule

`default_nettype wire

//--- src/sample_ring_buffer.sv
// ================================================
// byte ring with credit flow control to the host
// full ring drops new bytes, drop_count saturates
// host must not return more credits than it owns
// ================================================
`timescale 1ns/1ps
`default_nettype none
`include "logger_settings.svh"

module sample_ring_buffer (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   byte_wr,
  input  wire [7:0]             byte_data,
  input  wire                   host_credit,
  output logic                  host_valid,
  output logic [7:0]            host_data,
  output logic [`LOG_DIV_W-1:0] drop_count
);

  localparam int DEPTH   = `LOG_RING_DEPTH;
  localparam int AW      = $clog2(DEPTH);
  localparam int FW      = AW + 1;
  localparam int CREDITS = `LOG_HOST_CREDITS;
  localparam int CW      = $clog2(CREDITS + 1);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [FW-1:0] fill;      // bytes held, 0..DEPTH
  logic [CW-1:0] credits;   // bytes the host can still take
  logic          full;
  logic          push;
  logic          pop;

  assign full = fill == FW'(DEPTH);
  assign push = byte_wr && !full;
  assign pop  = (fill != '0) && (credits != '0); // oldest byte out

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= byte_data;
    if (pop)
      host_data <= mem[rd_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      credits    <= CW'(CREDITS);
      host_valid <= 1'b0;
      drop_count <= '0;
    end
    else
    begin
      host_valid <= pop; // pairs with host_data above
      if (push)
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^n
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
      case ({pop, host_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ; // spend and return cancel
      endcase
      if (byte_wr && full && drop_count != '1)
        drop_count <= drop_count + 1'b1;
    end
  end

  // a returned credit must match a byte still outstanding at the host
  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    host_credit |-> (credits < CW'(CREDITS)));

endmodule

`default_nettype wire

//--- src/accel_logger_top.sv
// ================================================
// ADXL355 sample logger, pps aligned sync
// spi burst reader into a credit-flow byte ring
// ================================================
`timescale 1ns/1ps
`default_nettype none
`include "logger_settings.svh"

module accel_logger_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   pps,
  input  wire                   reg_wr,
  input  wire [2:0]             reg_addr,
  input  wire [`LOG_DIV_W-1:0]  reg_wdata,
  input  wire                   adxl_miso,
  input  wire                   host_credit,
  output logic [`LOG_DIV_W-1:0] reg_rdata,
  output logic                  sync,
  output logic                  adxl_csn,
  output logic                  adxl_sclk,
  output logic                  adxl_mosi,
  output logic                  host_valid,
  output logic [7:0]            host_data
);

  logic                  enable;
  adxl_pkg::adxl_cmd_u   cmd;
  logic [`LOG_LEN_W-1:0] len;
  logic [`LOG_DIV_W-1:0] div;
  logic [`LOG_DIV_W-1:0] expect_syncs;
  logic [`LOG_DIV_W-1:0] sync_count;
  logic                  locked;
  logic [`LOG_DIV_W-1:0] drop_count;
  logic                  sync_tick;   // gen -> reader
  logic                  byte_wr;     // reader -> ring
  logic [7:0]            byte_data;

  logger_regs u_logger_regs (.clk, .rst, .reg_wr, .reg_addr, .reg_wdata, .sync_count,
    .locked, .drop_count, .reg_rdata, .enable, .cmd, .len, .div, .expect_syncs);

  pps_sync_gen u_pps_sync_gen (.clk, .rst, .pps, .div, .expect_syncs,
    .sync, .sync_tick, .sync_count, .locked);

  adxl_spi_reader u_adxl_spi_reader (.clk, .rst, .enable, .cmd, .len, .sync_tick,
    .adxl_miso, .adxl_csn, .adxl_sclk, .adxl_mosi, .byte_wr, .byte_data);

  sample_ring_buffer u_sample_ring_buffer (.clk, .rst, .byte_wr, .byte_data,
    .host_credit, .host_valid, .host_data, .drop_count);

endmodule

`default_nettype wire

//--- verification/adxl_spi_model.sv
// ================================================
// behavioral ADXL355 spi slave, mode 0, msb first
// data byte i of burst b is addr + i + 16*b, 8 bits
// first 8 bits of each burst are taken as command
// ================================================
`timescale 1ns/1ps
`default_nettype none

module adxl_spi_model (
  input  wire        csn,
  input  wire        sclk,
  input  wire        mosi,
  output logic       miso,
  output logic [7:0] cmd_seen    // last command byte received
);

  logic [7:0]  rx_sr;
  logic [7:0]  tx_byte;
  logic [15:0] burst_num;       // bursts completed so far
  int          bit_cnt;         // sclk rises in this burst
  int          idx;
  int          pos;

  initial
  begin
    miso      = 1'b0;
    cmd_seen  = '0;
    burst_num = '0;
    rx_sr     = '0;
    bit_cnt   = 0;
  end

  // burst start, counters back to zero
  always @(negedge csn)
  begin
    bit_cnt = 0;
    miso    = 1'b0;
  end

  // csn rise out of reset carries no command and is not counted
  always @(posedge csn)
    if (bit_cnt >= 8)
      burst_num = burst_num + 16'd1;

  // master samples on the rise, so the model samples mosi there too
  always @(posedge sclk)
  begin
    if (!csn)
    begin
      rx_sr   = {rx_sr[6:0], mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
        cmd_seen = rx_sr; // whole command in
    end
  end

  // next bit goes out on the fall
  always @(negedge sclk)
  begin
    if (!csn && bit_cnt >= 8)
    begin
      idx     = (bit_cnt - 8) / 8;
      pos     = (bit_cnt - 8) % 8;
      tx_byte = 8'(int'(cmd_seen[7:1]) + idx + 16 * int'(burst_num));
      miso    = tx_byte[7 - pos];
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_accel_logger_top.sv
// ================================================
// table driven test of the accelerometer logger
// rows run in order, ring drained between rows
// drop count is cumulative over all rows
// ================================================
`timescale 1ns/1ps
`default_nettype none
`include "logger_settings.svh"

module tb_accel_logger_top;

  localparam int NROWS    = 4;
  localparam int CREDITS  = `LOG_HOST_CREDITS;
  localparam int KEEP_MAX = `LOG_RING_DEPTH + `LOG_HOST_CREDITS;

  logic                  clk;
  logic                  rst;
  logic                  pps;
  logic                  reg_wr;
  logic [2:0]            reg_addr;
  logic [`LOG_DIV_W-1:0] reg_wdata;
  logic [`LOG_DIV_W-1:0] reg_rdata;
  logic                  adxl_miso;
  logic                  host_credit;
  logic                  sync;
  logic                  adxl_csn;
  logic                  adxl_sclk;
  logic                  adxl_mosi;
  logic                  host_valid;
  logic [7:0]            host_data;
  logic [7:0]            cmd_seen;

  // addr, len, div, pps period, credits (0 eager, 1 random, 2 withheld), bursts
  int row_tbl [NROWS][6] = '{
    '{'h00, 3, 100, 1000, 0, 6},
    '{'h08, 9, 400, 4000, 1, 5},
    '{'h11, 6, 200, 2000, 2, 3},
    '{'h08, 9, 400, 4000, 2, 8}
  };

  int          errors     = 0;
  int          policy     = 2;   // no credits until a row starts
  int          owed       = 0;   // bytes held by host, credit not yet returned
  int          bursts     = 0;
  int          pps_period = 0;   // 0 keeps pps low
  int          pps_cnt    = 0;
  int          exp_drop   = 0;
  logic        csn_q      = 1'b1;
  logic [31:0] lcg_state  = 32'h688909b4;
  logic [7:0]  rx_q [$];

  accel_logger_top u_accel_logger_top (.clk, .rst, .pps, .reg_wr, .reg_addr, .reg_wdata,
    .adxl_miso, .host_credit, .reg_rdata, .sync, .adxl_csn, .adxl_sclk, .adxl_mosi,
    .host_valid, .host_data);

  adxl_spi_model u_adxl_spi_model (.csn(adxl_csn), .sclk(adxl_sclk), .mosi(adxl_mosi),
    .miso(adxl_miso), .cmd_seen);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // host side, pps and burst counting, all on the falling edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (host_valid)
      begin
        rx_q.push_back(host_data);
        owed = owed + 1;
      end
      if (owed > CREDITS)
      begin
        errors = errors + 1;
        $display("%0t: host holds %0d bytes, more than its credits", $time, owed);
      end
      host_credit = (owed > 0) && (policy == 0 || (policy == 1 && lcg_next() > 32'h7fffffff));
      if (host_credit)
        owed = owed - 1;
      if (adxl_csn && !csn_q)
        bursts = bursts + 1; // csn rise ends a burst
      csn_q = adxl_csn;
      if (pps_period > 0)
      begin
        pps     = pps_cnt < 8;
        pps_cnt = (pps_cnt == pps_period - 1) ? 0 : pps_cnt + 1;
      end
      else
        pps = 1'b0;
    end
  end

  task automatic compare_value(input string name, input int expv, input int actv);
    if (expv !== actv)
    begin
      errors = errors + 1;
      $display("MISMATCH %0t %s expected %0h actual %0h", $time, name, expv, actv);
    end
  endtask

  task automatic write_reg(input logic [2:0] addr, input int data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data[`LOG_DIV_W-1:0];
    @(negedge clk);
    reg_wr    = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output int data);
    @(negedge clk);
    reg_addr = addr;
    @(negedge clk);
    data = int'(reg_rdata); // comb path, settled by now
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic run_row(input int r);
    int         addr;
    int         len;
    int         dv;
    int         per;
    int         base;
    int         cyc;
    int         hi;
    int         rd;
    logic [7:0] exp_q [$];
    addr = row_tbl[r][0];
    len  = row_tbl[r][1];
    dv   = row_tbl[r][2];
    per  = row_tbl[r][3];
    rx_q.delete();
    policy = row_tbl[r][4];
    write_reg(logger_pkg::REG_CMD, addr);
    write_reg(logger_pkg::REG_LEN, len);
    write_reg(logger_pkg::REG_DIV, dv);
    pps_cnt    = 0;
    pps_period = per;
    // reader is off here, csn must stay high across many sync periods
    cyc = 0;
    hi  = 0;
    for (int k = 0; k < 3 * per + 20; k++)
    begin
      @(negedge clk);
      if (adxl_csn !== 1'b1)
        cyc = cyc + 1;
      if (k >= per + 20 && sync === 1'b1)
        hi = hi + 1; // last two pps intervals, phase settled
    end
    if (cyc != 0)
    begin
      errors = errors + 1;
      $display("%0t: adxl_csn low for %0d cycles while disabled", $time, cyc);
    end
    // sync high for the first half of each of the 2*per/dv periods
    compare_value("sync", 2 * (per / dv) * (dv / 2), hi);
    read_reg(logger_pkg::REG_STAT_SYNC, rd);
    compare_value("sync_count", per / dv, rd);
    write_reg(logger_pkg::REG_EXPECT, per / dv);
    wait_cycles(4);
    read_reg(logger_pkg::REG_STAT_LOCK, rd);
    compare_value("locked", 1, rd);
    write_reg(logger_pkg::REG_EXPECT, per / dv + 1);
    wait_cycles(4);
    read_reg(logger_pkg::REG_STAT_LOCK, rd);
    compare_value("locked", 0, rd);
    // capture phase
    base = bursts;
    write_reg(logger_pkg::REG_CTRL, 1);
    cyc = 0;
    while (bursts - base < row_tbl[r][5] && cyc < 2 * row_tbl[r][5] * dv + per)
    begin
      @(negedge clk);
      cyc = cyc + 1;
    end
    write_reg(logger_pkg::REG_CTRL, 0);
    wait_cycles(40 * len + 100); // a burst already started runs to its end
    if (bursts - base < row_tbl[r][5])
    begin
      errors = errors + 1;
      $display("%0t: row %0d ran %0d bursts, wanted %0d", $time, r, bursts - base,
        row_tbl[r][5]);
    end
    compare_value("cmd_seen", addr * 2 + 1, int'(cmd_seen));
    for (int b = base; b < bursts; b++)
      for (int i = 0; i < len; i++)
        if (i % 3 != 2)
          exp_q.push_back(8'(addr + i + 16 * b));
    if (policy == 2)
    begin
      if (rx_q.size() > CREDITS)
      begin
        errors = errors + 1;
        $display("%0t: %0d host bytes sent without credits returned", $time, rx_q.size());
      end
      if (exp_q.size() > KEEP_MAX)
        exp_drop = exp_drop + exp_q.size() - KEEP_MAX;
      while (exp_q.size() > KEEP_MAX)
        void'(exp_q.pop_back()); // newest bytes were dropped
      policy = 1;
    end
    cyc = 0;
    while (rx_q.size() < exp_q.size() && cyc < 40 * KEEP_MAX + 10 * exp_q.size())
    begin
      @(negedge clk);
      cyc = cyc + 1;
    end
    wait_cycles(50); // any extra byte would show up here
    compare_value("host byte count", exp_q.size(), rx_q.size());
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++)
      compare_value("host_data", int'(exp_q[i]), int'(rx_q[i]));
    read_reg(logger_pkg::REG_STAT_DROP, rd);
    compare_value("drop_count", exp_drop, rd);
  endtask

  // watchdog sized from the table
  initial
  begin
    int lim;
    lim = 1000;
    for (int r = 0; r < NROWS; r++)
      lim = lim + 5 * row_tbl[r][3] + 3 * row_tbl[r][5] * row_tbl[r][2] + 3000;
    #(lim * 4);
    $display("watchdog expired after %0d cycles", lim);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    int rd;
    rst         = 1'b1;
    pps         = 1'b0;
    reg_wr      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    host_credit = 1'b0;
    wait_cycles(5);
    rst = 1'b0;
    compare_value("adxl_csn", 1, int'(adxl_csn));
    compare_value("adxl_sclk", 0, int'(adxl_sclk));
    compare_value("host_valid", 0, int'(host_valid));
    read_reg(logger_pkg::REG_STAT_LOCK, rd);
    compare_value("locked", 0, rd);
    for (int r = 0; r < NROWS; r++)
      run_row(r);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- accel_logger_top.f
+incdir+src
src/adxl_pkg.sv
src/logger_pkg.sv
src/pps_sync_gen.sv
src/logger_regs.sv
src/adxl_spi_reader.sv
src/sample_ring_buffer.sv
src/accel_logger_top.sv
verification/adxl_spi_model.sv
verification/tb_accel_logger_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the logger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_accel_logger_top \
  -f accel_logger_top.f \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
